//--- rtl/shot_pkg.sv
`default_nettype none

package shot_pkg;

    // Screen coordinates are signed so an object may sit partly off screen
    localparam int PIXEL_WIDTH = 11;

    // Positions are kept at 1/64 pixel resolution inside the movers
    localparam int FRAC_BITS = 6;
    localparam int FP_WIDTH  = PIXEL_WIDTH + FRAC_BITS;

    // The missile leaves the ship from this offset to the ship's top-left corner
    localparam int MISSILE_X_OFFSET = 15;
    localparam int MISSILE_Y_OFFSET = 0;

    // Upward speed in fixed-point units per frame, which is 4 pixels per frame
    localparam int MISSILE_Y_SPEED = -256;
    localparam int MISSILE_W       = 4;
    localparam int MISSILE_H       = 8;

    // The target sweeps along one fixed row at 2 pixels per frame
    localparam int TARGET_W     = 32;
    localparam int TARGET_H     = 16;
    localparam int TARGET_Y     = 64;
    localparam int TARGET_SPEED = 128;

    localparam int SCREEN_W    = 640;
    localparam int SCORE_WIDTH = 8;

    typedef logic signed [PIXEL_WIDTH-1:0] pixel_t;
    typedef logic signed [FP_WIDTH-1:0]    fixed_t;

    // One object on screen, top-left corner in whole pixels
    typedef struct packed {
        logic   active;
        pixel_t x;
        pixel_t y;
    } obj_pos_t;

    // Payload of one hit report
    typedef struct packed {
        logic [SCORE_WIDTH-1:0] score;
        logic [PIXEL_WIDTH-1:0] hit_x;
    } hit_report_t;

    typedef enum logic [1:0] {
        REPORT_IDLE,
        REPORT_REQ,
        REPORT_WAIT_ACK_LOW
    } report_state_t;

endpackage

`default_nettype wire

//--- rtl/missile_mover.sv
`default_nettype none

module missile_mover (
    input  logic               clk,
    input  logic               resetN,
    input  logic               frame_tick,
    input  logic               shot_press,
    input  logic               collision,
    input  shot_pkg::pixel_t   ship_x,
    input  shot_pkg::pixel_t   ship_y,
    output shot_pkg::obj_pos_t missile_pos
);

    // Fire key seen since the last frame tick
    logic shot_latched;
    logic active;

    // Position in fixed point, fraction in the low FRAC_BITS
    shot_pkg::fixed_t x_fp;
    shot_pkg::fixed_t y_fp;

    // Launch point and the next height after one frame of climbing
    shot_pkg::pixel_t launch_x;
    shot_pkg::pixel_t launch_y;
    shot_pkg::fixed_t next_y_fp;

    assign launch_x = shot_pkg::pixel_t'(ship_x + shot_pkg::MISSILE_X_OFFSET);
    assign launch_y = shot_pkg::pixel_t'(ship_y + shot_pkg::MISSILE_Y_OFFSET);

    // The horizontal speed is zero so only y moves during flight
    assign next_y_fp = shot_pkg::fixed_t'(y_fp + shot_pkg::MISSILE_Y_SPEED);

    // The shot latch is refreshed once per frame
    // A press in the tick cycle itself is dropped, as the tick clears the latch
    always_ff @(posedge clk or negedge resetN) begin
        if (!resetN) begin
            shot_latched <= 1'b0;
        end else if (frame_tick) begin
            shot_latched <= 1'b0;
        end else if (shot_press) begin
            shot_latched <= 1'b1;
        end
    end

    // Launch, climb and retire rules, evaluated only on a frame tick
    always_ff @(posedge clk or negedge resetN) begin
        if (!resetN) begin
            active <= 1'b0;
            x_fp   <= '0;
            y_fp   <= '0;
        end else if (collision) begin
            // A hit wins over a tick in the same cycle
            active <= 1'b0;
        end else if (frame_tick) begin
            if (shot_latched) begin
                // Fire, or relaunch from the ship when already in flight
                active <= 1'b1;
                x_fp   <= {launch_x, {shot_pkg::FRAC_BITS{1'b0}}};
                y_fp   <= {launch_y, {shot_pkg::FRAC_BITS{1'b0}}};
            end else if (active) begin
                if (next_y_fp[shot_pkg::FP_WIDTH-1]) begin
                    // Retire at the top edge instead of going negative
                    active <= 1'b0;
                end else begin
                    y_fp <= next_y_fp;
                end
            end
        end
    end

    // Dropping the fraction bits gives whole pixels
    assign missile_pos.active = active;
    assign missile_pos.x      = x_fp[shot_pkg::FP_WIDTH-1:shot_pkg::FRAC_BITS];
    assign missile_pos.y      = y_fp[shot_pkg::FP_WIDTH-1:shot_pkg::FRAC_BITS];

endmodule

`default_nettype wire

//--- rtl/target_mover.sv
`default_nettype none

module target_mover (
    input  logic               clk,
    input  logic               resetN,
    input  logic               frame_tick,
    input  logic               collision,
    output shot_pkg::obj_pos_t target_pos
);

    // Horizontal position in fixed point, the row never changes
    shot_pkg::fixed_t x_fp;

    // Low means moving right, high means moving left
    logic moving_left;

    // Candidate position after one frame in the current direction
    shot_pkg::fixed_t next_x_fp;

    // Rightmost legal x so that the whole box stays on screen
    shot_pkg::fixed_t right_edge_fp;

    // Left bounce happens at zero or below
    logic at_left_edge;

    assign right_edge_fp = shot_pkg::fixed_t'((shot_pkg::SCREEN_W - shot_pkg::TARGET_W)
                                              << shot_pkg::FRAC_BITS);

    always_comb begin
        if (moving_left) begin
            next_x_fp = shot_pkg::fixed_t'(x_fp - shot_pkg::TARGET_SPEED);
        end else begin
            next_x_fp = shot_pkg::fixed_t'(x_fp + shot_pkg::TARGET_SPEED);
        end
    end

    assign at_left_edge = next_x_fp[shot_pkg::FP_WIDTH-1] || (next_x_fp == '0);

    always_ff @(posedge clk or negedge resetN) begin
        if (!resetN) begin
            x_fp        <= '0;
            moving_left <= 1'b0;
        end else if (collision) begin
            // Respawn at the left edge heading right, ahead of any tick
            x_fp        <= '0;
            moving_left <= 1'b0;
        end else if (frame_tick) begin
            if (!moving_left && (next_x_fp >= right_edge_fp)) begin
                // Clamp on the right edge and turn around
                x_fp        <= right_edge_fp;
                moving_left <= 1'b1;
            end else if (moving_left && at_left_edge) begin
                x_fp        <= '0;
                moving_left <= 1'b0;
            end else begin
                x_fp <= next_x_fp;
            end
        end
    end

    // The target is always on screen
    assign target_pos.active = 1'b1;
    assign target_pos.x      = x_fp[shot_pkg::FP_WIDTH-1:shot_pkg::FRAC_BITS];
    assign target_pos.y      = shot_pkg::pixel_t'(shot_pkg::TARGET_Y);

endmodule

`default_nettype wire

//--- rtl/hit_detector.sv
`default_nettype none

module hit_detector (
    input  logic                  clk,
    input  logic                  resetN,
    input  shot_pkg::obj_pos_t    missile_pos,
    input  shot_pkg::obj_pos_t    target_pos,
    output logic                  collision,
    output logic                  report_req,
    input  logic                  report_ack,
    output shot_pkg::hit_report_t report
);

    logic overlap_x;
    logic overlap_y;
    logic overlap;

    // First cycle of an overlap, when no pulse has been sent for it yet
    logic hit_start;

    logic [shot_pkg::SCORE_WIDTH-1:0] score;

    // Target x captured with the hit that produced the latest score
    logic [shot_pkg::PIXEL_WIDTH-1:0] hit_x_q;

    // A hit arrived while a report was still in flight
    logic pending;

    // A new report goes out in this cycle
    logic send_report;

    shot_pkg::report_state_t report_state;

    // Box overlap of the registered positions, both objects must be on screen
    always_comb begin
        overlap_x = (missile_pos.x < target_pos.x + shot_pkg::TARGET_W) &&
                    (missile_pos.x + shot_pkg::MISSILE_W > target_pos.x);
        overlap_y = (missile_pos.y < target_pos.y + shot_pkg::TARGET_H) &&
                    (missile_pos.y + shot_pkg::MISSILE_H > target_pos.y);
        overlap   = missile_pos.active && target_pos.active && overlap_x && overlap_y;
    end

    // The movers clear one cycle after the pulse, so the overlap is still
    // visible while the pulse is high and must not retrigger it
    assign hit_start = overlap && !collision;

    assign send_report = (report_state == shot_pkg::REPORT_IDLE) && (collision || pending);

    always_ff @(posedge clk or negedge resetN) begin
        if (!resetN) begin
            collision    <= 1'b0;
            score        <= '0;
            pending      <= 1'b0;
            report_state <= shot_pkg::REPORT_IDLE;
        end else begin
            collision <= hit_start;

            // Score moves with the pulse and wraps past its top value
            if (hit_start) begin
                score <= score + 1'b1;
            end

            case (report_state)
                shot_pkg::REPORT_IDLE: begin
                    if (send_report) begin
                        report_state <= shot_pkg::REPORT_REQ;
                        pending      <= 1'b0;
                    end
                end
                shot_pkg::REPORT_REQ: begin
                    // Hits during a report are kept for a later request
                    if (collision) begin
                        pending <= 1'b1;
                    end
                    if (report_ack) begin
                        report_state <= shot_pkg::REPORT_WAIT_ACK_LOW;
                    end
                end
                shot_pkg::REPORT_WAIT_ACK_LOW: begin
                    if (collision) begin
                        pending <= 1'b1;
                    end
                    // The next request waits for ack to fall
                    if (!report_ack) begin
                        report_state <= shot_pkg::REPORT_IDLE;
                    end
                end
                default: begin
                    report_state <= shot_pkg::REPORT_IDLE;
                end
            endcase
        end
    end

    // Report payload, loaded once per request and held until the next one
    always_ff @(posedge clk) begin
        if (hit_start) begin
            hit_x_q <= target_pos.x;
        end
        if (send_report) begin
            report.score <= score;
            report.hit_x <= hit_x_q;
        end
    end

    assign report_req = (report_state == shot_pkg::REPORT_REQ);

endmodule

`default_nettype wire

//--- rtl/space_shot_top.sv
`default_nettype none

module space_shot_top (
    input  logic                  clk,
    input  logic                  resetN,
    input  logic                  frame_tick,
    input  logic                  shot_press,
    input  shot_pkg::pixel_t      ship_x,
    input  shot_pkg::pixel_t      ship_y,
    output shot_pkg::obj_pos_t    missile_pos,
    output shot_pkg::obj_pos_t    target_pos,
    output logic                  report_req,
    output shot_pkg::hit_report_t report,
    input  logic                  report_ack
);

    // One-cycle hit pulse fed back to both movers
    logic collision;

    // Missile launched from the ship and climbing once per frame
    missile_mover missile_mover_inst (
        .clk         (clk),
        .resetN      (resetN),
        .frame_tick  (frame_tick),
        .shot_press  (shot_press),
        .collision   (collision),
        .ship_x      (ship_x),
        .ship_y      (ship_y),
        .missile_pos (missile_pos)
    );

    // Target sweeping its row in step with the same frame tick
    target_mover target_mover_inst (
        .clk        (clk),
        .resetN     (resetN),
        .frame_tick (frame_tick),
        .collision  (collision),
        .target_pos (target_pos)
    );

    // Overlap, score and the outgoing hit report
    hit_detector hit_detector_inst (
        .clk         (clk),
        .resetN      (resetN),
        .missile_pos (missile_pos),
        .target_pos  (target_pos),
        .collision   (collision),
        .report_req  (report_req),
        .report_ack  (report_ack),
        .report      (report)
    );

endmodule

`default_nettype wire

//--- tb/frame_clock_gen.sv
`default_nettype none

module frame_clock_gen (
    output logic clk
);

    timeunit 1ns;
    timeprecision 1ps;

    // Half of the 100 ns system clock period
    localparam int HALF_PERIOD = 50;

    // Free-running clock, low at time zero so the first rising edge is at 50 ns
    initial begin
        clk = 1'b0;
        forever begin
            #HALF_PERIOD;
            clk = ~clk;
        end
    end

endmodule

`default_nettype wire

//--- tb/space_shot_sva.sv
`default_nettype none

module space_shot_sva (
    input logic                  clk,
    input logic                  resetN,
    input logic                  collision,
    input logic                  report_req,
    input logic                  report_ack,
    input shot_pkg::hit_report_t report
);

    timeunit 1ns;
    timeprecision 1ps;

    // A request may only fall after the receiver has answered it
    req_held_until_ack: assert property (@(posedge clk) disable iff (!resetN)
        report_req && !report_ack |=> report_req)
        else $error("report_req fell before report_ack was seen");

    // The payload must not move while a request is still up
    report_stable: assert property (@(posedge clk) disable iff (!resetN)
        report_req |=> !report_req || $stable(report))
        else $error("report changed while report_req was high");

    // Each hit gives exactly one pulse
    single_collision: assert property (@(posedge clk) disable iff (!resetN)
        collision |=> !collision)
        else $error("collision was high for two cycles in a row");

endmodule

bind hit_detector space_shot_sva space_shot_sva_inst (.*);

`default_nettype wire

//--- tb/space_shot_tb.sv
`default_nettype none

module space_shot_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD = 100;
    // Quiet cycles after every tick, enough for a collision to settle
    localparam int TICK_IDLE = 3;
    localparam int TICK_CYCLES = TICK_IDLE + 1;
    // Flights, the full sweep of about 600 ticks and three hits
    localparam int TEST_TICKS = 700;
    localparam int WATCHDOG_NS = (16 + (TEST_TICKS * TICK_CYCLES * 3) / 2) * CLK_PERIOD;
    localparam int TARGET_STEP = shot_pkg::TARGET_SPEED / (1 << shot_pkg::FRAC_BITS);
    localparam int MISSILE_STEP = -shot_pkg::MISSILE_Y_SPEED / (1 << shot_pkg::FRAC_BITS);
    localparam int RIGHT_EDGE = shot_pkg::SCREEN_W - shot_pkg::TARGET_W;

    logic clk;
    logic resetN;
    logic frame_tick;
    logic shot_press;
    logic report_ack;
    logic report_req;
    shot_pkg::pixel_t ship_x;
    shot_pkg::pixel_t ship_y;
    shot_pkg::obj_pos_t missile_pos;
    shot_pkg::obj_pos_t target_pos;
    shot_pkg::hit_report_t report;

    int value_errors;
    int other_errors;
    int exp_score;
    // Reference model of the target sweep
    int model_x;
    bit model_left;

    frame_clock_gen frame_clock_gen_inst (.clk(clk));

    space_shot_top space_shot_top_inst (
        .clk         (clk),
        .resetN      (resetN),
        .frame_tick  (frame_tick),
        .shot_press  (shot_press),
        .ship_x      (ship_x),
        .ship_y      (ship_y),
        .missile_pos (missile_pos),
        .target_pos  (target_pos),
        .report_req  (report_req),
        .report      (report),
        .report_ack  (report_ack)
    );

    task automatic compare_value(input string name, input int actual, input int expected);
        assert (actual == expected) else begin
            value_errors++;
            $display("mismatch at %0d ns: %s is %0d, expected %0d", $time, name, actual, expected);
        end
    endtask

    task automatic note_failure(input string what);
        other_errors++;
        $display("error at %0d ns: %s", $time, what);
    endtask

    // Inputs change 10 ns after the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #10;
    endtask

    // One frame step of the target under the bounce rules
    function automatic void step_target(inout int x, inout bit left);
        if (left) begin
            x = x - TARGET_STEP;
            if (x <= 0) begin
                x = 0;
                left = 1'b0;
            end
        end else begin
            x = x + TARGET_STEP;
            if (x >= RIGHT_EDGE) begin
                x = RIGHT_EDGE;
                left = 1'b1;
            end
        end
    endfunction

    // Missile box rows that meet the target box rows
    function automatic bit in_target_row(input int y);
        return (y < shot_pkg::TARGET_Y + shot_pkg::TARGET_H) &&
               (y + shot_pkg::MISSILE_H > shot_pkg::TARGET_Y);
    endfunction

    task automatic pulse_tick();
        frame_tick = 1'b1;
        next_cycle();
        frame_tick = 1'b0;
        step_target(model_x, model_left);
        repeat (TICK_IDLE) next_cycle();
    endtask

    task automatic fire(input int sx, input int sy);
        ship_x = shot_pkg::pixel_t'(sx);
        ship_y = shot_pkg::pixel_t'(sy);
        shot_press = 1'b1;
        next_cycle();
        shot_press = 1'b0;
    endtask

    task automatic missile_at(input int x, input int y);
        compare_value("missile_pos.active", missile_pos.active, 1);
        compare_value("missile_pos.x", missile_pos.x, x);
        compare_value("missile_pos.y", missile_pos.y, y);
    endtask

    // Poll report_req for a bounded number of cycles
    task automatic wait_req(input bit level);
        int n;
        n = 0;
        while (report_req !== level && n < 20) begin
            next_cycle();
            n++;
        end
        assert (report_req === level) else note_failure($sformatf("report_req never went %0d", level));
    endtask

    task automatic answer_ack();
        report_ack = 1'b1;
        wait_req(1'b0);
        next_cycle();
        report_ack = 1'b0;
    endtask

    // Aims a shot from row sy at the modeled target and flies it into the hit
    task automatic produce_hit(input int sy, input bit req_held,
                               input shot_pkg::hit_report_t held, output int hit_x);
        int n;
        int tx;
        bit tl;
        n = 0;
        while (!in_target_row(sy - n * MISSILE_STEP)) begin
            n++;
        end
        // The target also steps on the launch tick, hence n + 1 steps
        tx = model_x;
        tl = model_left;
        repeat (n + 1) step_target(tx, tl);
        fire(tx + 16 - shot_pkg::MISSILE_X_OFFSET, sy);
        repeat (n) begin
            pulse_tick();
            compare_value("report_req", report_req, req_held);
            if (req_held) begin
                compare_value("report", report, held);
            end
        end
        pulse_tick();
        hit_x = model_x;
        // Respawn of the target after the collision pulse
        model_x = 0;
        model_left = 1'b0;
        exp_score++;
        compare_value("missile_pos.active", missile_pos.active, 0);
        compare_value("target_pos.x", target_pos.x, 0);
    endtask

    task automatic reset_test();
        compare_value("report_req", report_req, 0);
        compare_value("missile_pos.active", missile_pos.active, 0);
        compare_value("target_pos.active", target_pos.active, 1);
        compare_value("target_pos.x", target_pos.x, 0);
        compare_value("target_pos.y", target_pos.y, shot_pkg::TARGET_Y);
    endtask

    task automatic launch_test();
        int sx;
        int y;
        sx = $urandom % 600;
        fire(sx, 400);
        pulse_tick();
        missile_at(sx + shot_pkg::MISSILE_X_OFFSET, 400);
        y = 400;
        repeat (5) begin
            pulse_tick();
            y = y - MISSILE_STEP;
            missile_at(sx + shot_pkg::MISSILE_X_OFFSET, y);
        end
        // A second shot in flight starts over from the ship
        sx = $urandom % 600;
        fire(sx, 380);
        pulse_tick();
        missile_at(sx + shot_pkg::MISSILE_X_OFFSET, 380);
    endtask

    task automatic retire_test();
        int y;
        y = 10;
        fire(300, y);
        pulse_tick();
        missile_at(300 + shot_pkg::MISSILE_X_OFFSET, y);
        while (y - MISSILE_STEP >= 0) begin
            pulse_tick();
            y = y - MISSILE_STEP;
            missile_at(300 + shot_pkg::MISSILE_X_OFFSET, y);
        end
        pulse_tick();
        compare_value("missile_pos.active", missile_pos.active, 0);
        compare_value("report_req", report_req, 0);
    endtask

    task automatic sweep_test();
        bit seen_right;
        bit seen_left;
        int n;
        seen_right = 1'b0;
        seen_left = 1'b0;
        n = 0;
        // One sweep out to the right edge and back takes under this many ticks
        while (!seen_left && n < 2 * RIGHT_EDGE / TARGET_STEP + 8) begin
            pulse_tick();
            n++;
            compare_value("target_pos.x", target_pos.x, model_x);
            if (target_pos.x == RIGHT_EDGE) begin
                seen_right = 1'b1;
            end
            if (seen_right && target_pos.x == 0) begin
                seen_left = 1'b1;
            end
        end
        assert (seen_left) else note_failure("target did not bounce at both screen edges");
        // After touching the left edge the target heads right again
        pulse_tick();
        compare_value("target_pos.x", target_pos.x, model_x);
    endtask

    task automatic hit_test();
        int hx;
        produce_hit(100, 1'b0, '0, hx);
        wait_req(1'b1);
        compare_value("report.score", report.score, exp_score);
        compare_value("report.hit_x", report.hit_x, hx);
        answer_ack();
        repeat (3) next_cycle();
        compare_value("report_req", report_req, 0);
    endtask

    task automatic backpressure_test();
        int hx;
        shot_pkg::hit_report_t first;
        produce_hit(100, 1'b0, '0, hx);
        wait_req(1'b1);
        compare_value("report.score", report.score, exp_score);
        compare_value("report.hit_x", report.hit_x, hx);
        // The first report must stay on the bus until it is answered
        first.score = exp_score[shot_pkg::SCORE_WIDTH-1:0];
        first.hit_x = hx[shot_pkg::PIXEL_WIDTH-1:0];
        // Second hit while the first report waits for its ack
        produce_hit(120, 1'b1, first, hx);
        compare_value("report_req", report_req, 1);
        compare_value("report", report, first);
        answer_ack();
        wait_req(1'b1);
        compare_value("report.score", report.score, exp_score);
        compare_value("report.hit_x", report.hit_x, hx);
        answer_ack();
        repeat (3) next_cycle();
        compare_value("report_req", report_req, 0);
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("error: run did not finish within %0d ns", WATCHDOG_NS);
        $display("Checks failed");
        $finish;
    end

    initial begin
        void'($urandom(8911));
        resetN = 1'b0;
        frame_tick = 1'b0;
        shot_press = 1'b0;
        report_ack = 1'b0;
        ship_x = '0;
        ship_y = '0;
        value_errors = 0;
        other_errors = 0;
        exp_score = 0;
        model_x = 0;
        model_left = 1'b0;
        repeat (16) next_cycle();
        resetN = 1'b1;
        next_cycle();
        reset_test();
        launch_test();
        retire_test();
        sweep_test();
        hit_test();
        backpressure_test();
        $display("errors: %0d value, %0d other", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- space_shot.f
rtl/shot_pkg.sv
rtl/missile_mover.sv
rtl/target_mover.sv
rtl/hit_detector.sv
rtl/space_shot_top.sv
tb/frame_clock_gen.sv
tb/space_shot_sva.sv
tb/space_shot_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the space_shot testbench with Verilator, run it, and judge the run from its log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

rm -rf obj_dir "$LOG"

verilator --binary --timing --assert -Wno-fatal \
    -f space_shot.f \
    --top-module space_shot_tb \
    -o space_shot_sim \
    && ./obj_dir/space_shot_sim > "$LOG" 2>&1 \
    ; cat "$LOG" 2>/dev/null \
    ; grep -q "All checks passed" "$LOG" \
    && echo "Simulation PASSED" \
    || { echo "Simulation FAILED, see $LOG"; exit 1; }
